//--- vpu_pkg.sv
//================================================
// Types shared by the SIMD execution cluster
// Lane data slice, element width and opcodes
// Issue-to-result latency and element-size helpers
//================================================
package vpu_pkg;

    typedef logic [63:0] bus64_t;               // One lane's slice of a vector register

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    typedef enum logic [4:0] {
        VADD  = 5'd0,
        VSUB  = 5'd1,
        VMUL  = 5'd2,
        VMACC = 5'd3,
        VMADD = 5'd4,
        VMIN  = 5'd5,
        VMINU = 5'd6,
        VMAX  = 5'd7,
        VMAXU = 5'd8,
        VSLL  = 5'd9,
        VSRL  = 5'd10,
        VSRA  = 5'd11,
        VAND  = 5'd12,
        VOR   = 5'd13,
        VXOR  = 5'd14,
        VID   = 5'd15
    } instr_type_t;

    localparam int EXE_LATENCY = 2;             // Cycles from issue to valid_o

    function automatic int unsigned sew_bits(input sew_t sew);
        return 32'd8 << sew;                    // 8, 16, 32 or 64
    endfunction

    // All ones over the low element of the given width
    function automatic bus64_t sew_mask(input sew_t sew);
        return (sew == SEW_64) ? '1 : ((64'd1 << sew_bits(sew)) - 64'd1);
    endfunction

endpackage

//--- vaddsub.sv
//================================================
// vaddsub: element-wise add and subtract
// Carry chain is cut at every element boundary
//================================================
`timescale 1ns/1ps

module vaddsub (
    input  logic            sub_i,              // 1 gives b-a
    input  vpu_pkg::sew_t   sew_i,
    input  vpu_pkg::bus64_t data_a_i,
    input  vpu_pkg::bus64_t data_b_i,
    output vpu_pkg::bus64_t data_vd_o
);
    import vpu_pkg::*;

    logic [7:0] elem_start;                     // Byte k opens a new element
    bus64_t     opnd_a;
    logic [8:0] byte_sum;
    logic       carry;

    always_comb begin
        case (sew_i)
            SEW_8:   elem_start = 8'hFF;
            SEW_16:  elem_start = 8'h55;
            SEW_32:  elem_start = 8'h11;
            default: elem_start = 8'h01;        // SEW_64
        endcase
    end

    assign opnd_a = sub_i ? ~data_a_i : data_a_i;  // Inverted for subtract

    // Byte ripple, restarted at the first byte of each element
    always_comb begin
        carry = 1'b0;
        for (int k = 0; k < 8; k++) begin
            if (elem_start[k]) begin
                carry = sub_i;                  // The +1 of two's complement
            end
            byte_sum = {1'b0, data_b_i[8*k +: 8]} + {1'b0, opnd_a[8*k +: 8]} + {8'd0, carry};
            data_vd_o[8*k +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

endmodule

//--- vmul.sv
//================================================
// vmul: element-wise multiplier, low half only
// Packed product is registered once
//================================================
`timescale 1ns/1ps

module vmul (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  vpu_pkg::sew_t   sew_i,
    input  vpu_pkg::bus64_t data_vs1_i,
    input  vpu_pkg::bus64_t data_vs2_i,
    output vpu_pkg::bus64_t data_vd_o
);
    import vpu_pkg::*;

    bus64_t product;                            // Low halves, packed per element

    // Low half is the same for signed and unsigned operands
    always_comb begin
        product = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    product[8*i +: 8] = data_vs1_i[8*i +: 8] * data_vs2_i[8*i +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    product[16*i +: 16] = data_vs1_i[16*i +: 16] * data_vs2_i[16*i +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    product[32*i +: 32] = data_vs1_i[32*i +: 32] * data_vs2_i[32*i +: 32];
                end
            end
            default: begin
                product = data_vs1_i * data_vs2_i;  // SEW_64
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            data_vd_o <= '0;
        end else begin
            data_vd_o <= product;
        end
    end

endmodule

//--- vcomp.sv
//================================================
// vcomp: element-wise minimum and maximum
// Signed or unsigned order chosen by the opcode
//================================================
`timescale 1ns/1ps

module vcomp (
    input  vpu_pkg::instr_type_t instr_type_i,
    input  vpu_pkg::sew_t        sew_i,
    input  vpu_pkg::bus64_t      data_vs1_i,
    input  vpu_pkg::bus64_t      data_vs2_i,
    output vpu_pkg::bus64_t      data_vd_o
);
    import vpu_pkg::*;

    int unsigned elem_bits;
    bus64_t      elem_mask;
    bus64_t      flip;                          // Element MSB for signed forms
    logic        is_max;
    bus64_t      elem_a;
    bus64_t      elem_b;
    bus64_t      pick;
    logic        a_lower;

    assign elem_bits = sew_bits(sew_i);
    assign elem_mask = sew_mask(sew_i);
    assign is_max    = (instr_type_i == VMAX) || (instr_type_i == VMAXU);

    // Toggling the sign bit maps signed order onto unsigned order
    assign flip = (instr_type_i == VMIN || instr_type_i == VMAX) ?
                  (elem_mask & ~(elem_mask >> 1)) : '0;

    always_comb begin
        data_vd_o = '0;
        for (int i = 0; i < 8; i++) begin
            elem_a    = (data_vs1_i >> (i * elem_bits)) & elem_mask;  // Zero past last element
            elem_b    = (data_vs2_i >> (i * elem_bits)) & elem_mask;
            a_lower   = (elem_a ^ flip) < (elem_b ^ flip);
            pick      = (a_lower ^ is_max) ? elem_a : elem_b;
            data_vd_o = data_vd_o | (pick << (i * elem_bits));
        end
    end

endmodule

//--- vshift.sv
//================================================
// vshift: element-wise SLL, SRL and SRA
// Amount masked to log2 of the element width
//================================================
`timescale 1ns/1ps

module vshift (
    input  vpu_pkg::instr_type_t instr_type_i,
    input  vpu_pkg::sew_t        sew_i,
    input  vpu_pkg::bus64_t      data_vs1_i,
    input  vpu_pkg::bus64_t      data_vs2_i,
    output vpu_pkg::bus64_t      data_vd_o
);
    import vpu_pkg::*;

    int unsigned elem_bits;
    bus64_t      elem_mask;
    bus64_t      elem_vs2;
    bus64_t      sign_fill;                     // Element sign extended to 64 bits
    bus64_t      shifted;
    logic [5:0]  shamt;

    assign elem_bits = sew_bits(sew_i);
    assign elem_mask = sew_mask(sew_i);

    always_comb begin
        data_vd_o = '0;
        for (int i = 0; i < 8; i++) begin
            elem_vs2  = (data_vs2_i >> (i * elem_bits)) & elem_mask;
            shamt     = 6'(data_vs1_i >> (i * elem_bits)) & 6'(elem_bits - 1);
            sign_fill = elem_vs2[elem_bits - 1] ? (elem_vs2 | ~elem_mask) : elem_vs2;
            case (instr_type_i)
                VSLL:    shifted = (elem_vs2 << shamt) & elem_mask;
                VSRL:    shifted = elem_vs2 >> shamt;
                VSRA:    shifted = bus64_t'($signed(sign_fill) >>> shamt) & elem_mask;
                default: shifted = '0;
            endcase
            data_vd_o = data_vd_o | (shifted << (i * elem_bits));
        end
    end

endmodule

//--- functional_unit.sv
//================================================
// functional_unit: one 64-bit lane of the cluster
// Multiplier operand steering, second product
// register, accumulate adder and result select
//================================================
`timescale 1ns/1ps

module functional_unit #(
    parameter int LANE_ID = 0
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vpu_pkg::instr_type_t instr_type_i,      // Issue-time opcode for the multiplier
    input  vpu_pkg::sew_t        sew_i,
    input  vpu_pkg::bus64_t      data_vs1_i,
    input  vpu_pkg::bus64_t      data_vs2_i,
    input  vpu_pkg::bus64_t      data_old_vd_i,
    input  vpu_pkg::instr_type_t sel_instr_type_i,  // Stage-2 copy, picks the result
    input  vpu_pkg::sew_t        sel_sew_i,
    input  vpu_pkg::bus64_t      sel_vs1_i,
    input  vpu_pkg::bus64_t      sel_vs2_i,
    input  vpu_pkg::bus64_t      sel_old_vd_i,
    output vpu_pkg::bus64_t      data_vd_o
);
    import vpu_pkg::*;

    bus64_t      mul_vs2;                       // Second multiplier operand
    bus64_t      mul_d1;                        // Product after the vmul register
    bus64_t      mul_q;                         // Product aligned with stage 2
    bus64_t      add_a;
    bus64_t      add_b;
    bus64_t      result_addsub;
    bus64_t      result_comp;
    bus64_t      result_shift;
    bus64_t      vid_result;
    int unsigned vid_bits;
    int unsigned vid_count;                     // Elements per lane

    assign mul_vs2 = (instr_type_i == VMADD) ? data_old_vd_i : data_vs2_i;

    vmul vmul_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .sew_i      (sew_i),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (mul_vs2),
        .data_vd_o  (mul_d1)
    );

    // Second product stage keeps the accumulate add off the multiplier path
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mul_q <= '0;
        end else begin
            mul_q <= mul_d1;
        end
    end

    assign add_a = (sel_instr_type_i inside {VMACC, VMADD}) ? mul_q : sel_vs1_i;
    assign add_b = (sel_instr_type_i == VMACC) ? sel_old_vd_i : sel_vs2_i;  // VMADD adds vs2

    vaddsub vaddsub_inst (
        .sub_i     (sel_instr_type_i == VSUB),
        .sew_i     (sel_sew_i),
        .data_a_i  (add_a),
        .data_b_i  (add_b),
        .data_vd_o (result_addsub)
    );

    vcomp vcomp_inst (
        .instr_type_i (sel_instr_type_i),
        .sew_i        (sel_sew_i),
        .data_vs1_i   (sel_vs1_i),
        .data_vs2_i   (sel_vs2_i),
        .data_vd_o    (result_comp)
    );

    vshift vshift_inst (
        .instr_type_i (sel_instr_type_i),
        .sew_i        (sel_sew_i),
        .data_vs1_i   (sel_vs1_i),
        .data_vs2_i   (sel_vs2_i),
        .data_vd_o    (result_shift)
    );

    assign vid_bits  = sew_bits(sel_sew_i);
    assign vid_count = 32'd8 >> sel_sew_i;

    // Element i of this lane holds LANE_ID*vid_count+i
    always_comb begin
        vid_result = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < vid_count) begin
                vid_result = vid_result |
                    ((64'(LANE_ID * vid_count + i) & sew_mask(sel_sew_i)) << (i * vid_bits));
            end
        end
    end

    always_comb begin
        case (sel_instr_type_i)
            VADD, VSUB, VMACC, VMADD: data_vd_o = result_addsub;
            VMUL:                     data_vd_o = mul_q;
            VMIN, VMINU, VMAX, VMAXU: data_vd_o = result_comp;
            VSLL, VSRL, VSRA:         data_vd_o = result_shift;
            VAND:                     data_vd_o = sel_vs1_i & sel_vs2_i;
            VOR:                      data_vd_o = sel_vs1_i | sel_vs2_i;
            VXOR:                     data_vd_o = sel_vs1_i ^ sel_vs2_i;
            VID:                      data_vd_o = vid_result;
            default:                  data_vd_o = '0;   // Undefined encodings
        endcase
    end

endmodule

//--- exe_pipe.sv
//================================================
// exe_pipe: instruction delay line of the cluster
// Carries valid, opcode, width and operands to
// the output select of every lane
//================================================
`timescale 1ns/1ps

module exe_pipe #(
    parameter int NUM_LANES = 2
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    valid_i,
    input  vpu_pkg::instr_type_t    instr_type_i,
    input  vpu_pkg::sew_t           sew_i,
    input  logic [NUM_LANES*64-1:0] data_vs1_i,
    input  logic [NUM_LANES*64-1:0] data_vs2_i,
    input  logic [NUM_LANES*64-1:0] data_old_vd_i,
    output logic                    sel_valid_o,
    output vpu_pkg::instr_type_t    sel_instr_type_o,
    output vpu_pkg::sew_t           sel_sew_o,
    output logic [NUM_LANES*64-1:0] sel_vs1_o,
    output logic [NUM_LANES*64-1:0] sel_vs2_o,
    output logic [NUM_LANES*64-1:0] sel_old_vd_o
);
    import vpu_pkg::*;

    typedef struct packed {
        logic                    valid;
        instr_type_t             instr_type;
        sew_t                    sew;
        logic [NUM_LANES*64-1:0] vs1;
        logic [NUM_LANES*64-1:0] vs2;
        logic [NUM_LANES*64-1:0] old_vd;
    } stage_t;

    stage_t stage_d;
    stage_t stage_q [EXE_LATENCY];              // Last entry drives the lanes

    assign stage_d = '{valid_i, instr_type_i, sew_i, data_vs1_i, data_vs2_i, data_old_vd_i};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < EXE_LATENCY; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            stage_q[0] <= stage_d;
            for (int s = 1; s < EXE_LATENCY; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign sel_valid_o      = stage_q[EXE_LATENCY-1].valid;
    assign sel_instr_type_o = stage_q[EXE_LATENCY-1].instr_type;
    assign sel_sew_o        = stage_q[EXE_LATENCY-1].sew;
    assign sel_vs1_o        = stage_q[EXE_LATENCY-1].vs1;
    assign sel_vs2_o        = stage_q[EXE_LATENCY-1].vs2;
    assign sel_old_vd_o     = stage_q[EXE_LATENCY-1].old_vd;

endmodule

//--- simd_exe_unit.sv
//================================================
// simd_exe_unit: SIMD execution cluster top
// Instruction pipe plus one functional unit
// per 64-bit lane
//================================================
`timescale 1ns/1ps

module simd_exe_unit #(
    parameter int NUM_LANES = 2
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    valid_i,        // One-cycle issue strobe
    input  vpu_pkg::instr_type_t    instr_type_i,
    input  vpu_pkg::sew_t           sew_i,
    input  logic [NUM_LANES*64-1:0] data_vs1_i,
    input  logic [NUM_LANES*64-1:0] data_vs2_i,
    input  logic [NUM_LANES*64-1:0] data_old_vd_i,
    output logic                    valid_o,        // Result strobe, two cycles after issue
    output logic [NUM_LANES*64-1:0] data_vd_o
);
    import vpu_pkg::*;

    instr_type_t             sel_instr_type;
    sew_t                    sel_sew;
    logic [NUM_LANES*64-1:0] sel_vs1;
    logic [NUM_LANES*64-1:0] sel_vs2;
    logic [NUM_LANES*64-1:0] sel_old_vd;

    exe_pipe #(
        .NUM_LANES (NUM_LANES)
    ) pipe_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .valid_i          (valid_i),
        .instr_type_i     (instr_type_i),
        .sew_i            (sew_i),
        .data_vs1_i       (data_vs1_i),
        .data_vs2_i       (data_vs2_i),
        .data_old_vd_i    (data_old_vd_i),
        .sel_valid_o      (valid_o),
        .sel_instr_type_o (sel_instr_type),
        .sel_sew_o        (sel_sew),
        .sel_vs1_o        (sel_vs1),
        .sel_vs2_o        (sel_vs2),
        .sel_old_vd_o     (sel_old_vd)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        functional_unit #(
            .LANE_ID (l)
        ) fu_inst (
            .clk_i            (clk_i),
            .rstn_i           (rstn_i),
            .instr_type_i     (instr_type_i),
            .sew_i            (sew_i),
            .data_vs1_i       (data_vs1_i[64*l +: 64]),
            .data_vs2_i       (data_vs2_i[64*l +: 64]),
            .data_old_vd_i    (data_old_vd_i[64*l +: 64]),
            .sel_instr_type_i (sel_instr_type),
            .sel_sew_i        (sel_sew),
            .sel_vs1_i        (sel_vs1[64*l +: 64]),
            .sel_vs2_i        (sel_vs2[64*l +: 64]),
            .sel_old_vd_i     (sel_old_vd[64*l +: 64]),
            .data_vd_o        (data_vd_o[64*l +: 64])
        );
    end

endmodule

//--- simd_exe_unit_checker.sv
//================================================
// Assertions on the SIMD cluster top level
// Issue-to-result timing, reset and X checks
//================================================
`timescale 1ns/1ps

module simd_exe_unit_checker #(
    parameter int NUM_LANES = 2
) (
    input logic                    clk_i,
    input logic                    rstn_i,
    input logic                    valid_i,
    input logic                    valid_o,
    input logic [NUM_LANES*64-1:0] data_vd_o
);
    import vpu_pkg::*;

    int assert_fails = 0;                       // Count of failed assertions

    valid_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o == $past(valid_i, EXE_LATENCY))
        else begin
            $error("valid_o does not follow valid_i by the pipe latency");
            assert_fails = assert_fails + 1;
        end

    valid_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else begin
            $error("valid_o high during reset");
            assert_fails = assert_fails + 1;
        end

    data_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> !$isunknown(data_vd_o))
        else begin
            $error("data_vd_o has unknown bits while valid_o is high");
            assert_fails = assert_fails + 1;
        end

endmodule

bind simd_exe_unit simd_exe_unit_checker #(.NUM_LANES(NUM_LANES)) chk_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .valid_i   (valid_i),
    .valid_o   (valid_o),
    .data_vd_o (data_vd_o)
);

//--- tb_result_monitor.sv
//================================================
// Result checker for the SIMD cluster testbench
// Reference model, expected queue, per-test lines
//================================================
`timescale 1ns/1ps

module tb_result_monitor (
    input logic         clk_i,
    input logic         rstn_i,
    input logic         valid_o,
    input logic [127:0] data_vd_o
);
    import vpu_pkg::*;

    string        name_q[$];
    logic [127:0] exp_q[$];
    int           pass_cnt = 0;
    int           fail_cnt = 0;

    task automatic push(input string name, input logic [127:0] expected);
        name_q.push_back(name);
        exp_q.push_back(expected);
    endtask

    // Element-wise reference for two lanes
    function automatic logic [127:0] model(input instr_type_t op, input sew_t sew,
                                           input logic [127:0] vs1, input logic [127:0] vs2,
                                           input logic [127:0] old);
        int           w;
        int           n;
        int           pos;
        logic [63:0]  m;
        logic [63:0]  msb;
        logic [63:0]  a;
        logic [63:0]  b;
        logic [63:0]  c;
        logic [63:0]  sa;
        logic [63:0]  sb;
        logic [63:0]  r;
        logic [127:0] res;
        w   = 8 << int'(sew);
        n   = 64 / w;
        m   = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        msb = 64'd1 << (w - 1);
        res = '0;
        for (int l = 0; l < 2; l++) begin
            for (int i = 0; i < n; i++) begin
                pos = 64 * l + w * i;
                a   = 64'(vs1 >> pos) & m;
                b   = 64'(vs2 >> pos) & m;
                c   = 64'(old >> pos) & m;
                sa  = (a & msb) ? (a | ~m) : a;   // Sign extended copies
                sb  = (b & msb) ? (b | ~m) : b;
                case (op)
                    VADD:    r = b + a;
                    VSUB:    r = b - a;
                    VMUL:    r = a * b;
                    VMACC:   r = a * b + c;
                    VMADD:   r = a * c + b;
                    VMIN:    r = ($signed(sa) < $signed(sb)) ? a : b;
                    VMINU:   r = (a < b) ? a : b;
                    VMAX:    r = ($signed(sa) > $signed(sb)) ? a : b;
                    VMAXU:   r = (a > b) ? a : b;
                    VSLL:    r = b << (a & (w - 1));
                    VSRL:    r = b >> (a & (w - 1));
                    VSRA:    r = 64'($signed(sb) >>> (a & (w - 1)));
                    VAND:    r = a & b;
                    VOR:     r = a | b;
                    VXOR:    r = a ^ b;
                    VID:     r = 64'(l * n + i);
                    default: r = '0;
                endcase
                res = res | (128'(r & m) << pos);
            end
        end
        return res;
    endfunction

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk_i) begin
        string        name;
        logic [127:0] expected;
        if (rstn_i && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("valid_o pulsed with no instruction outstanding");
                fail_cnt++;
            end else begin
                name     = name_q.pop_front();
                expected = exp_q.pop_front();
                if (data_vd_o === expected) begin
                    $display("PASS %s", name);
                    pass_cnt++;
                end else begin
                    $display("[ERROR] %s expected %h actual %h", name, expected, data_vd_o);
                    fail_cnt++;
                end
            end
        end
    end

endmodule

//--- tb_simd_exe_unit.sv
//================================================
// Testbench top for the SIMD execution cluster
// Clock, reset, directed table, random phase
// and the closing result count
//================================================
`timescale 1ns/1ps

module tb_simd_exe_unit;
    import vpu_pkg::*;

    typedef struct {
        string        name;
        instr_type_t  op;
        sew_t         sew;
        logic [127:0] vs1;
        logic [127:0] vs2;
        logic [127:0] old;
        logic [127:0] exp;
    } vec_t;

    logic         clk_i = 1'b0;
    logic         rstn_i = 1'b1;
    logic         valid_i = 1'b0;
    instr_type_t  instr_type_i = VADD;
    sew_t         sew_i = SEW_8;
    logic [127:0] data_vs1_i = '0;
    logic [127:0] data_vs2_i = '0;
    logic [127:0] data_old_vd_i = '0;
    logic         valid_o;
    logic [127:0] data_vd_o;
    logic [31:0]  lfsr = 32'h9379_0891;
    logic         missing = 1'b0;

    vec_t vectors [19] = '{
        '{"add8", VADD, SEW_8, {64'h1, {4{16'h0101}}}, {64'hFF, {4{16'h00FF}}}, '0,
          {64'h0, {4{16'h0100}}}},
        '{"sub16", VSUB, SEW_16, {4{32'h0000_0001}}, {4{32'h0001_0000}}, '0,
          {4{32'h0001_FFFF}}},
        '{"add32", VADD, SEW_32, {2{64'hFFFF_FFFF_0000_0001}}, {2{64'h0000_0001_FFFF_FFFF}},
          '0, '0},
        '{"add64", VADD, SEW_64, {2{64'h1}}, {64'hFFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF}, '0,
          {64'h1_0000_0000, 64'h0}},
        '{"mul8", VMUL, SEW_8, {{8{8'h10}}, {8{8'h03}}}, {{8{8'h10}}, {8{8'h55}}}, '0,
          {64'h0, {8{8'hFF}}}},
        '{"macc16", VMACC, SEW_16, {8{16'h2}}, {8{16'h3}}, {8{16'h10}}, {8{16'h16}}},
        '{"madd32", VMADD, SEW_32, {4{32'h2}}, {4{32'h1}}, {4{32'h5}}, {4{32'hB}}},
        '{"min8", VMIN, SEW_8, {16{8'h80}}, {16{8'h7F}}, '0, {16{8'h80}}},
        '{"minu8", VMINU, SEW_8, {16{8'h80}}, {16{8'h7F}}, '0, {16{8'h7F}}},
        '{"max16", VMAX, SEW_16, {8{16'h8000}}, {8{16'h7FFF}}, '0, {8{16'h7FFF}}},
        '{"maxu32", VMAXU, SEW_32, {4{32'h8000_0000}}, {4{32'h7FFF_FFFF}}, '0,
          {4{32'h8000_0000}}},
        '{"min64", VMIN, SEW_64, {2{64'h8000_0000_0000_0000}}, {2{64'h1}}, '0,
          {2{64'h8000_0000_0000_0000}}},
        '{"sll8", VSLL, SEW_8, {16{8'h09}}, {16{8'h81}}, '0, {16{8'h02}}},
        '{"sra16", VSRA, SEW_16, {8{16'h0011}}, {8{16'h8000}}, '0, {8{16'hC000}}},
        '{"srl32", VSRL, SEW_32, {4{32'h24}}, {4{32'h8000_0000}}, '0, {4{32'h0800_0000}}},
        '{"and64", VAND, SEW_64, {16{8'hF0}}, {8{16'hFF00}}, '0, {8{16'hF000}}},
        '{"or64", VOR, SEW_64, {16{8'hF0}}, {8{16'hFF00}}, '0, {8{16'hFFF0}}},
        '{"xor64", VXOR, SEW_64, {16{8'hF0}}, {8{16'hFF00}}, '0, {8{16'h0FF0}}},
        '{"vid8", VID, SEW_8, '1, '1, '1, {64'h0F0E_0D0C_0B0A_0908, 64'h0706_0504_0302_0100}}
    };

    simd_exe_unit #(.NUM_LANES(2)) uut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (valid_i),
        .instr_type_i  (instr_type_i),
        .sew_i         (sew_i),
        .data_vs1_i    (data_vs1_i),
        .data_vs2_i    (data_vs2_i),
        .data_old_vd_i (data_old_vd_i),
        .valid_o       (valid_o),
        .data_vd_o     (data_vd_o)
    );

    tb_result_monitor mon (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .valid_o   (valid_o),
        .data_vd_o (data_vd_o)
    );

    always #20 clk_i = ~clk_i;                  // 40 ns period

    // Galois LFSR stepped once per bit taken
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[126:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic issue(input string name, input instr_type_t op, input sew_t sew,
                         input logic [127:0] vs1, input logic [127:0] vs2,
                         input logic [127:0] old, input logic [127:0] expected);
        @(negedge clk_i);
        valid_i       = 1'b1;
        instr_type_i  = op;
        sew_i         = sew;
        data_vs1_i    = vs1;
        data_vs2_i    = vs2;
        data_old_vd_i = old;
        mon.push(name, expected);
    endtask

    initial begin
        instr_type_t  op;
        sew_t         sew;
        logic [127:0] a;
        logic [127:0] b;
        logic [127:0] c;
        int           wait_cnt;
        #1;
        rstn_i = 1'b0;                          // Edge clears the DUT registers
        repeat (10) @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (3) @(negedge clk_i);            // Idle cycles with no pulse expected
        foreach (vectors[t]) begin
            issue(vectors[t].name, vectors[t].op, vectors[t].sew, vectors[t].vs1,
                  vectors[t].vs2, vectors[t].old, vectors[t].exp);
        end
        for (int t = 0; t < 48; t++) begin
            if (rand_bits(1) == 0) begin
                @(negedge clk_i);
                valid_i = 1'b0;                 // Bubble between issues
            end
            op  = instr_type_t'(rand_bits(4));
            sew = sew_t'(rand_bits(2));
            a   = rand_bits(128);
            b   = rand_bits(128);
            c   = rand_bits(128);
            issue($sformatf("rand%0d_%s_%s", t, op.name(), sew.name()), op, sew, a, b, c,
                  mon.model(op, sew, a, b, c));
        end
        @(negedge clk_i);
        valid_i  = 1'b0;
        wait_cnt = 0;
        while (mon.exp_q.size() != 0 && wait_cnt < 20) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (mon.exp_q.size() != 0) begin
            $display("Timed out with %0d results never delivered", mon.exp_q.size());
            missing = 1'b1;
        end
        repeat (4) @(negedge clk_i);            // Catch any stray pulse
        $display("Passed %0d, failed %0d, assertion failures %0d", mon.pass_cnt,
                 mon.fail_cnt, uut.chk_inst.assert_fails);
        if (mon.fail_cnt == 0 && uut.chk_inst.assert_fails == 0 && !missing) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- simd_exe_unit.f
vpu_pkg.sv
vaddsub.sv
vmul.sv
vcomp.sv
vshift.sv
functional_unit.sv
exe_pipe.sv
simd_exe_unit.sv
simd_exe_unit_checker.sv
tb_result_monitor.sv
tb_simd_exe_unit.sv
